// File: testbench/cpu_tests.txt
// Number of tests, then per test: n_prog n_data n_store halt_pc
// followed by program words, data pairs (addr value), store pairs (addr value)
0004
// Forwarding through ALU chains
000e 0000 0004 001c
a701 b105 b203 0312 1431 2543 3654 9570 9671 0333 9372 1821 9873 f000
0100 000b 0102 0003 0104 0010 0106 fffe
// Load-use stalls
000c 0003 0004 0018
a702 8170 0211 8371 1423 9472 8571 9573 9274 867f 9675 f000
0200 1234 0202 0011 01fe beef
0204 2457 0206 0011 0208 2468 020a beef
// Branches taken and not taken
0019 0000 0004 0032
a703 b101 1211 c002 9170 c202 9171 9172 1321 c601 9173 9374 c402 b420 de40 9175
9476 d240 a67f b6ff 0561 cc01 9177 9577 f000
0300 0001 0308 ffff 030c 0020 030e 8000
// Byte loads and shifts
000d 0000 0005 001a
a704 a1c3 b15a 9170 4214 5314 541f 9271 9372 9473 a412 9474 f000
0400 c35a 0402 35a0 0404 fc35 0406 ffff 0408 12ff

// File: vlog.f
hw/cpu_pkg.sv
hw/register_file.sv
hw/alu.sv
hw/hazard_unit.sv
hw/branch_unit.sv
hw/mem_arbiter.sv
hw/cpu.sv
testbench/tb_clock.sv
testbench/cpu_props.sv
testbench/tb_cpu.sv

// File: Makefile
.PHONY: run clean

obj_dir/Vtb_cpu: vlog.f $(wildcard hw/*.sv testbench/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f vlog.f

run: obj_dir/Vtb_cpu
	./obj_dir/Vtb_cpu | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: testbench/tb_cpu.sv
module tb_cpu;

	logic           clk;
	logic           rst_n;
	logic           mem_req;
	cpu_pkg::word_t mem_addr;
	logic           mem_we;
	cpu_pkg::word_t mem_wdata;
	logic           mem_ack;
	cpu_pkg::word_t mem_rdata;
	logic           hlt;
	cpu_pkg::word_t pc_out;

	logic [15:0] tests_mem [0:1023];  // Raw contents of the data file
	logic [15:0] ram [0:32767];       // Word indexed, byte address bit 0 dropped
	logic [15:0] log_addr [$];        // Stores in the order they hit memory
	logic [15:0] log_data [$];
	int unsigned lcg_state = 56940;
	int          n_tests;

	tb_clock i_clk (.clk(clk));

	cpu i_cpu (
		.clk       (clk),
		.rst_n     (rst_n),
		.mem_req   (mem_req),
		.mem_addr  (mem_addr),
		.mem_we    (mem_we),
		.mem_wdata (mem_wdata),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata),
		.hlt       (hlt),
		.pc_out    (pc_out)
	);

	// 0 to 3 cycles of ack delay
	function automatic int unsigned next_delay();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return (lcg_state >> 16) % 4;
	endfunction

	// ----------------------------------------------------------
	// Memory model, four-phase slave
	// ----------------------------------------------------------
	initial begin
		int unsigned delay;
		mem_ack   = 1'b0;
		mem_rdata = '0;
		forever begin
			@(negedge clk);
			if (rst_n && mem_req && !mem_ack) begin
				delay = next_delay();
				repeat (delay) @(negedge clk);
				if (mem_we) begin
					ram[mem_addr[15:1]] = mem_wdata;
					log_addr.push_back(mem_addr);
					log_data.push_back(mem_wdata);
				end else begin
					mem_rdata = ram[mem_addr[15:1]];  // Valid while ack high
				end
				mem_ack = 1'b1;
				do
					@(negedge clk);
				while (mem_req);
				delay = next_delay();
				repeat (delay) @(negedge clk);
				mem_ack = 1'b0;
			end
		end
	end

	// Hang guard, 2000 cycles per test
	initial begin
		#1;
		repeat (2000 * n_tests) @(posedge clk);
		$display("Run stopped: the CPU did not halt within the cycle limit");
		$display("TEST FAILED");
		$finish;
	end

	// ----------------------------------------------------------
	// Test loop
	// ----------------------------------------------------------
	initial begin
		int ptr;
		int n_prog;
		int n_data;
		int n_store;
		int test_errs;
		int n_failed;
		logic [15:0] exp_pc;
		logic [15:0] exp_addr;
		logic [15:0] exp_data;
		logic req_after;
		rst_n    = 1'b0;
		n_failed = 0;
		$readmemh("testbench/cpu_tests.txt", tests_mem);
		n_tests = int'(tests_mem[0]);
		ptr     = 1;
		for (int t = 0; t < n_tests; t++) begin
			n_prog  = int'(tests_mem[ptr]);  // Header of four words
			n_data  = int'(tests_mem[ptr + 1]);
			n_store = int'(tests_mem[ptr + 2]);
			exp_pc  = tests_mem[ptr + 3];
			ptr     = ptr + 4;
			@(negedge clk);
			rst_n = 1'b0;
			for (int i = 0; i < 32768; i++)
				ram[i] = 16'(i) ^ 16'h6c3b;  // Fill tied to the address
			for (int i = 0; i < n_prog; i++)
				ram[i] = tests_mem[ptr + i];  // Program from address 0
			ptr = ptr + n_prog;
			for (int i = 0; i < n_data; i++)
				ram[tests_mem[ptr + 2 * i] >> 1] = tests_mem[ptr + 2 * i + 1];
			ptr = ptr + 2 * n_data;
			log_addr.delete();
			log_data.delete();
			repeat (10) @(negedge clk);
			rst_n = 1'b1;

			while (!hlt)
				@(negedge clk);
			req_after = 1'b0;
			repeat (20) begin
				@(negedge clk);
				if (mem_req)
					req_after = 1'b1;  // Nothing may run after HLT
			end

			test_errs = 0;
			assert (log_addr.size() == n_store)
			else begin
				$display("[FAIL] %0t test %0d: %0d stores seen, %0d expected",
					$time, t, log_addr.size(), n_store);
				test_errs++;
			end
			for (int i = 0; i < n_store; i++) begin
				exp_addr = tests_mem[ptr + 2 * i];
				exp_data = tests_mem[ptr + 2 * i + 1];
				if (i < log_addr.size()) begin
					assert (log_addr[i] == exp_addr && log_data[i] == exp_data)
					else begin
						$display("[FAIL] %0t test %0d: store %0d got %h=%h, expected %h=%h",
							$time, t, i, log_addr[i], log_data[i], exp_addr, exp_data);
						test_errs++;
					end
				end
			end
			ptr = ptr + 2 * n_store;
			assert (pc_out == exp_pc)
			else begin
				$display("[FAIL] %0t test %0d: pc_out %h, expected %h",
					$time, t, pc_out, exp_pc);
				test_errs++;
			end
			assert (!req_after)
			else begin
				$display("[FAIL] %0t test %0d: memory request after halt", $time, t);
				test_errs++;
			end
			if (test_errs != 0)
				n_failed++;
			$display("test %0d: %s, %0d stores, pc_out %h", t,
				(test_errs == 0) ? "ok" : "wrong", log_addr.size(), pc_out);
		end

		$display("%0d tests run, %0d ok, %0d wrong", n_tests, n_tests - n_failed, n_failed);
		if (n_failed == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: testbench/cpu_props.sv
module cpu_props (
	input logic           clk,
	input logic           rst_n,
	input logic           mem_req,
	input logic           mem_ack,
	input cpu_pkg::word_t mem_addr,
	input logic           hlt
);

	// ----------------------------------------------------------
	// Memory handshake
	// ----------------------------------------------------------
	// New request only once the last ack has gone low
	a_req_after_ack_low : assert property (@(posedge clk) disable iff (!rst_n)
		$rose(mem_req) |-> !$past(mem_ack))
		else $error("mem_req rose while mem_ack was still high");

	a_addr_stable : assert property (@(posedge clk) disable iff (!rst_n)
		(mem_req && $past(mem_req)) |-> $stable(mem_addr))  // Held for the whole access
		else $error("mem_addr changed during a request");

	// ----------------------------------------------------------
	// Reset values
	// ----------------------------------------------------------
	a_reset_quiet : assert property (@(posedge clk)
		(!rst_n && $past(rst_n) == 1'b0) |-> (!hlt && !mem_req))
		else $error("hlt or mem_req high during reset");

endmodule

bind cpu cpu_props i_cpu_props (
	.clk      (clk),
	.rst_n    (rst_n),
	.mem_req  (mem_req),
	.mem_ack  (mem_ack),
	.mem_addr (mem_addr),
	.hlt      (hlt)
);

// File: testbench/tb_clock.sv
module tb_clock (
	output logic clk
);

	// Free running, period 20
	initial begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

endmodule

// File: hw/cpu.sv
module cpu (
	input  logic           clk,
	input  logic           rst_n,
	output logic           mem_req,
	output cpu_pkg::word_t mem_addr,
	output logic           mem_we,
	output cpu_pkg::word_t mem_wdata,
	input  logic           mem_ack,
	input  cpu_pkg::word_t mem_rdata,
	output logic           hlt,
	output cpu_pkg::word_t pc_out
);

	// Stall control and arbiter side
	logic adv_back, adv_front, load_stall, fetch_stop;
	logic fetch_req, fetch_busy, fetch_done, fetch_got;
	logic data_req, data_busy, data_done, data_got;
	cpu_pkg::word_t rd_word, fetch_buf, data_buf, fetch_word, load_word;
	cpu_pkg::word_t pc;
	logic hlt_q;

	// Decode
	logic id_valid, id_is_halt;
	cpu_pkg::word_t id_instr, id_pc_plus, id_data_a, id_data_b;
	cpu_pkg::opcode_e id_op;
	cpu_pkg::reg_idx_t id_rs, id_rt;

	// Execute
	logic ex_valid, ex_is_alu, ex_is_shift, ex_is_load, ex_wen, taken;
	cpu_pkg::word_t ex_instr, ex_pc_plus, ex_data_a, ex_data_b;
	cpu_pkg::reg_idx_t ex_rs, ex_rt;
	cpu_pkg::opcode_e ex_op;
	cpu_pkg::fwd_e fwd_a, fwd_b;
	cpu_pkg::word_t op_a, op_b, alu_b, alu_result, ex_result, ex_eaddr, target;
	cpu_pkg::flag_t alu_flags, alu_flag_wen;

	// Memory and writeback
	logic mem_valid, mem_regw, wb_valid, wb_regw;
	cpu_pkg::opcode_e mem_op;
	cpu_pkg::reg_idx_t mem_rd, wb_rd;
	cpu_pkg::word_t mem_result, mem_eaddr, mem_sdata, mem_data_out, wb_data;

	// Back half moves on any cycle the port is quiet
	assign adv_back  = !fetch_busy && !data_busy;
	assign adv_front = adv_back && !load_stall;  // PC and IF/ID also wait on load-use

	// ----------------------------------------------------------
	// Fetch
	// ----------------------------------------------------------
	assign fetch_req  = !fetch_stop && !fetch_got;
	assign fetch_word = fetch_got ? fetch_buf : rd_word;  // Parked word or fresh one
	assign pc_out     = pc;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc        <= cpu_pkg::reset_pc;
			fetch_got <= 1'b0;
			data_got  <= 1'b0;
			id_valid  <= 1'b0;
		end else begin
			if (adv_front && !fetch_stop)
				pc <= taken ? target : pc + cpu_pkg::instr_step;
			if (adv_front)
				fetch_got <= 1'b0;
			else if (fetch_done)
				fetch_got <= 1'b1;  // Fetch finished under another stall
			if (adv_back)
				data_got <= 1'b0;
			else if (data_done)
				data_got <= 1'b1;  // Never repeat a store
			if (adv_front)
				id_valid <= !fetch_stop && !taken;
		end
	end

	// Words held across stalls
	always_ff @(posedge clk) begin
		if (fetch_done && !adv_front)
			fetch_buf <= rd_word;
		if (data_done && !adv_back)
			data_buf <= rd_word;
		if (adv_front) begin
			id_instr   <= fetch_word;
			id_pc_plus <= pc + cpu_pkg::instr_step;
		end
	end

	// ----------------------------------------------------------
	// Decode
	// ----------------------------------------------------------
	assign id_op = cpu_pkg::opcode_e'(id_instr[15:12]);
	// LHB and LLB merge into the old rd
	assign id_rs = (id_op == cpu_pkg::op_lhb || id_op == cpu_pkg::op_llb) ? id_instr[11:8]
		: id_instr[7:4];
	assign id_rt = (id_op == cpu_pkg::op_sw) ? id_instr[11:8] : id_instr[3:0];  // Store data
	assign id_is_halt = id_valid && id_op == cpu_pkg::op_hlt && !taken;

	always_ff @(posedge clk) begin
		if (!rst_n)
			ex_valid <= 1'b0;
		else if (adv_back)
			ex_valid <= id_valid && !load_stall && !taken;  // Bubble on stall or squash
	end

	always_ff @(posedge clk) begin
		if (adv_back) begin
			ex_instr   <= id_instr;
			ex_pc_plus <= id_pc_plus;
			ex_data_a  <= id_data_a;
			ex_data_b  <= id_data_b;
			ex_rs      <= id_rs;
			ex_rt      <= id_rt;
		end
	end

	// ----------------------------------------------------------
	// Execute
	// ----------------------------------------------------------
	assign ex_op       = cpu_pkg::opcode_e'(ex_instr[15:12]);
	assign ex_is_alu   = (ex_instr[15:12] < 4'd6);
	assign ex_is_shift = (ex_op == cpu_pkg::op_sll || ex_op == cpu_pkg::op_sra);
	assign ex_is_load  = ex_valid && ex_op == cpu_pkg::op_lw;
	assign ex_wen = ex_is_alu || ex_op == cpu_pkg::op_lw || ex_op == cpu_pkg::op_lhb
		|| ex_op == cpu_pkg::op_llb;

	always_comb begin
		case (fwd_a)
			cpu_pkg::fwd_mem: op_a = mem_result;
			cpu_pkg::fwd_wb:  op_a = wb_data;
			default:          op_a = ex_data_a;
		endcase
		case (fwd_b)
			cpu_pkg::fwd_mem: op_b = mem_result;
			cpu_pkg::fwd_wb:  op_b = wb_data;
			default:          op_b = ex_data_b;
		endcase
	end

	assign alu_b = ex_is_shift ? {12'h000, ex_instr[3:0]} : op_b;  // Shift amount unsigned

	always_comb begin
		case (ex_op)
			cpu_pkg::op_lhb: ex_result = {ex_instr[7:0], op_a[7:0]};
			cpu_pkg::op_llb: ex_result = {op_a[15:8], ex_instr[7:0]};
			default:         ex_result = alu_result;
		endcase
	end

	// Base word aligned, offset in words
	assign ex_eaddr = (op_a & 16'hfffe) + {{11{ex_instr[3]}}, ex_instr[3:0], 1'b0};

	always_ff @(posedge clk) begin
		if (!rst_n)
			mem_valid <= 1'b0;
		else if (adv_back)
			mem_valid <= ex_valid;
	end

	always_ff @(posedge clk) begin
		if (adv_back) begin
			mem_op     <= ex_op;
			mem_rd     <= ex_instr[11:8];
			mem_regw   <= ex_wen;
			mem_result <= ex_result;
			mem_eaddr  <= ex_eaddr;
			mem_sdata  <= op_b;  // Forwarded store data
		end
	end

	// ----------------------------------------------------------
	// Memory and writeback
	// ----------------------------------------------------------
	assign data_req = mem_valid && !data_got
		&& (mem_op == cpu_pkg::op_lw || mem_op == cpu_pkg::op_sw);
	assign load_word    = data_got ? data_buf : rd_word;
	assign mem_data_out = (mem_op == cpu_pkg::op_lw) ? load_word : mem_result;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
			hlt_q    <= 1'b0;
		end else if (adv_back) begin
			wb_valid <= mem_valid;
			if (mem_valid && mem_op == cpu_pkg::op_hlt)
				hlt_q <= 1'b1;  // Sticky until reset
		end
	end

	always_ff @(posedge clk) begin
		if (adv_back) begin
			wb_rd   <= mem_rd;
			wb_regw <= mem_regw;
			wb_data <= mem_data_out;
		end
	end

	assign hlt = hlt_q;

	// ----------------------------------------------------------
	// Units
	// ----------------------------------------------------------
	mem_arbiter i_arb (
		.clk        (clk),
		.rst_n      (rst_n),
		.fetch_req  (fetch_req),
		.fetch_addr (pc),
		.data_req   (data_req),
		.data_we    (mem_op == cpu_pkg::op_sw),
		.data_addr  (mem_eaddr),
		.data_wdata (mem_sdata),
		.fetch_busy (fetch_busy),
		.data_busy  (data_busy),
		.fetch_done (fetch_done),
		.data_done  (data_done),
		.rd_word    (rd_word),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.mem_we     (mem_we),
		.mem_wdata  (mem_wdata),
		.mem_ack    (mem_ack),
		.mem_rdata  (mem_rdata)
	);

	register_file i_rf (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_sel_1  (id_rs),
		.rd_sel_2  (id_rt),
		.wr_sel    (wb_rd),
		.wr_en     (wb_valid && wb_regw),
		.wr_data   (wb_data),
		.rd_data_1 (id_data_a),
		.rd_data_2 (id_data_b)
	);

	alu i_alu (
		.in_a     (op_a),
		.in_b     (alu_b),
		.op       (ex_op),
		.result   (alu_result),
		.flags    (alu_flags),
		.flag_wen (alu_flag_wen)
	);

	hazard_unit i_hazard (
		.clk         (clk),
		.rst_n       (rst_n),
		.ex_rs       (ex_rs),
		.ex_rt       (ex_rt),
		.mem_rd      (mem_rd),
		.wb_rd       (wb_rd),
		.mem_wen     (mem_valid && mem_regw),
		.wb_wen      (wb_valid && wb_regw),
		.ex_is_load  (ex_is_load),
		.ex_rd       (ex_instr[11:8]),
		.id_rs       (id_rs),
		.id_rt       (id_rt),
		.id_is_halt  (id_is_halt),
		.fwd_a       (fwd_a),
		.fwd_b       (fwd_b),
		.load_stall  (load_stall),
		.fetch_stop  (fetch_stop)
	);

	branch_unit i_branch (
		.clk           (clk),
		.rst_n         (rst_n),
		.ex_valid      (ex_valid),
		.flush         (!adv_back),  // EX result not committed this cycle
		.flags         (alu_flags),
		.flag_wen      (alu_flag_wen),
		.is_branch     (ex_op == cpu_pkg::op_b),
		.is_branch_reg (ex_op == cpu_pkg::op_br),
		.cond          (cpu_pkg::cond_e'(ex_instr[11:9])),
		.offset        (ex_instr[8:0]),
		.pc_plus       (ex_pc_plus),
		.reg_target    (op_a),
		.taken         (taken),
		.target        (target)
	);

endmodule

// File: hw/mem_arbiter.sv
module mem_arbiter (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           fetch_req,
	input  cpu_pkg::word_t fetch_addr,
	input  logic           data_req,
	input  logic           data_we,
	input  cpu_pkg::word_t data_addr,
	input  cpu_pkg::word_t data_wdata,
	output logic           fetch_busy,
	output logic           data_busy,
	output logic           fetch_done,
	output logic           data_done,
	output cpu_pkg::word_t rd_word,
	output logic           mem_req,
	output cpu_pkg::word_t mem_addr,
	output logic           mem_we,
	output cpu_pkg::word_t mem_wdata,
	input  logic           mem_ack,
	input  cpu_pkg::word_t mem_rdata
);

	cpu_pkg::arb_state_e state;
	logic grant_data;  // Owner of the access in flight
	logic start;

	assign start = (state == cpu_pkg::arb_idle) && (data_req || fetch_req);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= cpu_pkg::arb_idle;
			mem_req    <= 1'b0;
			mem_we     <= 1'b0;
			grant_data <= 1'b0;
			fetch_done <= 1'b0;
			data_done  <= 1'b0;
		end else begin
			fetch_done <= 1'b0;  // Pulses
			data_done  <= 1'b0;
			case (state)
				cpu_pkg::arb_idle: begin
					if (start) begin
						mem_req    <= 1'b1;
						mem_we     <= data_req && data_we;  // Data is older, wins
						grant_data <= data_req;
						state      <= cpu_pkg::arb_req;
					end
				end
				cpu_pkg::arb_req: begin
					if (mem_ack) begin
						mem_req    <= 1'b0;
						fetch_done <= !grant_data;
						data_done  <= grant_data;
						state      <= cpu_pkg::arb_wait_low;
					end
				end
				cpu_pkg::arb_wait_low: begin
					if (!mem_ack)
						state <= cpu_pkg::arb_idle;  // Port free again
				end
				default: state <= cpu_pkg::arb_idle;
			endcase
		end
	end

	// Address and data stay put for the whole transaction
	always_ff @(posedge clk) begin
		if (start) begin
			mem_addr  <= data_req ? data_addr : fetch_addr;
			mem_wdata <= data_wdata;
		end
		if (state == cpu_pkg::arb_req && mem_ack)
			rd_word <= mem_rdata;
	end

	assign fetch_busy = fetch_req && !fetch_done;
	assign data_busy  = data_req && !data_done;

endmodule

// File: hw/branch_unit.sv
module branch_unit (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           ex_valid,
	input  logic           flush,
	input  cpu_pkg::flag_t flags,
	input  cpu_pkg::flag_t flag_wen,
	input  logic           is_branch,
	input  logic           is_branch_reg,
	input  cpu_pkg::cond_e cond,
	input  logic [8:0]     offset,
	input  cpu_pkg::word_t pc_plus,
	input  cpu_pkg::word_t reg_target,
	output logic           taken,
	output cpu_pkg::word_t target
);

	cpu_pkg::flag_t flag_q;
	logic z, v, n;
	logic cond_true;

	// Per-flag write, only when the EX instruction commits
	always_ff @(posedge clk) begin
		if (!rst_n)
			flag_q <= '0;
		else if (ex_valid && !flush)
			flag_q <= (flag_q & ~flag_wen) | (flags & flag_wen);
	end

	assign z = flag_q[cpu_pkg::flag_z];
	assign v = flag_q[cpu_pkg::flag_v];
	assign n = flag_q[cpu_pkg::flag_n];

	always_comb begin
		case (cond)
			cpu_pkg::cond_ne:   cond_true = !z;
			cpu_pkg::cond_eq:   cond_true = z;
			cpu_pkg::cond_gt:   cond_true = !z && !n;
			cpu_pkg::cond_lt:   cond_true = n;
			cpu_pkg::cond_ge:   cond_true = z || !n;
			cpu_pkg::cond_le:   cond_true = z || n;
			cpu_pkg::cond_ovfl: cond_true = v;
			default:            cond_true = 1'b1;  // Unconditional
		endcase
	end

	assign taken  = ex_valid && (is_branch || is_branch_reg) && cond_true;
	assign target = is_branch_reg ? reg_target
		: pc_plus + {{6{offset[8]}}, offset, 1'b0};  // Word offset from PC+2

endmodule

// File: hw/hazard_unit.sv
module hazard_unit (
	input  logic              clk,
	input  logic              rst_n,
	input  cpu_pkg::reg_idx_t ex_rs,
	input  cpu_pkg::reg_idx_t ex_rt,
	input  cpu_pkg::reg_idx_t mem_rd,
	input  cpu_pkg::reg_idx_t wb_rd,
	input  logic              mem_wen,
	input  logic              wb_wen,
	input  logic              ex_is_load,
	input  cpu_pkg::reg_idx_t ex_rd,
	input  cpu_pkg::reg_idx_t id_rs,
	input  cpu_pkg::reg_idx_t id_rt,
	input  logic              id_is_halt,
	output cpu_pkg::fwd_e     fwd_a,
	output cpu_pkg::fwd_e     fwd_b,
	output logic              load_stall,
	output logic              fetch_stop
);

	logic halt_seen;

	// Youngest writer first
	always_comb begin
		if (mem_wen && mem_rd == ex_rs)
			fwd_a = cpu_pkg::fwd_mem;
		else if (wb_wen && wb_rd == ex_rs)
			fwd_a = cpu_pkg::fwd_wb;
		else
			fwd_a = cpu_pkg::fwd_none;
		if (mem_wen && mem_rd == ex_rt)
			fwd_b = cpu_pkg::fwd_mem;
		else if (wb_wen && wb_rd == ex_rt)
			fwd_b = cpu_pkg::fwd_wb;
		else
			fwd_b = cpu_pkg::fwd_none;
	end

	// Load data only exists after MEM, one bubble needed
	assign load_stall = ex_is_load && (ex_rd == id_rs || ex_rd == id_rt);

	always_ff @(posedge clk) begin
		if (!rst_n)
			halt_seen <= 1'b0;
		else if (id_is_halt)
			halt_seen <= 1'b1;
	end

	assign fetch_stop = halt_seen || id_is_halt;  // Blocks the fetch behind HLT at once

endmodule

// File: hw/alu.sv
module alu (
	input  cpu_pkg::word_t   in_a,
	input  cpu_pkg::word_t   in_b,
	input  cpu_pkg::opcode_e op,
	output cpu_pkg::word_t   result,
	output cpu_pkg::flag_t   flags,
	output cpu_pkg::flag_t   flag_wen
);

	logic ovf;

	always_comb begin
		result   = in_a + in_b;
		ovf      = 1'b0;
		flag_wen = '0;
		case (op)
			cpu_pkg::op_add: begin
				result   = in_a + in_b;  // Wraps
				ovf      = (in_a[15] == in_b[15]) && (result[15] != in_a[15]);
				flag_wen = '1;
			end
			cpu_pkg::op_sub: begin
				result   = in_a - in_b;
				ovf      = (in_a[15] != in_b[15]) && (result[15] != in_a[15]);
				flag_wen = '1;
			end
			cpu_pkg::op_xor: begin
				result                   = in_a ^ in_b;
				flag_wen[cpu_pkg::flag_z] = 1'b1;
			end
			cpu_pkg::op_and: begin
				result                   = in_a & in_b;
				flag_wen[cpu_pkg::flag_z] = 1'b1;
			end
			cpu_pkg::op_sll: begin
				result                   = in_a << in_b[3:0];
				flag_wen[cpu_pkg::flag_z] = 1'b1;
			end
			cpu_pkg::op_sra: begin
				result                   = cpu_pkg::word_t'($signed(in_a) >>> in_b[3:0]);
				flag_wen[cpu_pkg::flag_z] = 1'b1;
			end
			default: ;  // No flag change outside the ALU group
		endcase
		flags                  = '0;
		flags[cpu_pkg::flag_z] = (result == '0);
		flags[cpu_pkg::flag_v] = ovf;
		flags[cpu_pkg::flag_n] = result[15];
	end

endmodule

// File: hw/register_file.sv
module register_file (
	input  logic              clk,
	input  logic              rst_n,
	input  cpu_pkg::reg_idx_t rd_sel_1,
	input  cpu_pkg::reg_idx_t rd_sel_2,
	input  cpu_pkg::reg_idx_t wr_sel,
	input  logic              wr_en,
	input  cpu_pkg::word_t    wr_data,
	output cpu_pkg::word_t    rd_data_1,
	output cpu_pkg::word_t    rd_data_2
);

	cpu_pkg::word_t regs [16];  // r0 is a normal register

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_sel] <= wr_data;
		end
	end

	// Write-through so decode sees the writeback value
	assign rd_data_1 = (wr_en && wr_sel == rd_sel_1) ? wr_data : regs[rd_sel_1];
	assign rd_data_2 = (wr_en && wr_sel == rd_sel_2) ? wr_data : regs[rd_sel_2];

endmodule

// File: hw/cpu_pkg.sv
package cpu_pkg;

	// ----------------------------------------------------------
	// Widths
	// ----------------------------------------------------------
	typedef logic [15:0] word_t;     // Data, address and instruction word
	typedef logic [3:0]  reg_idx_t;  // Register number
	typedef logic [2:0]  flag_t;     // Z, V, N

	// Bit positions inside flag_t
	localparam int flag_z = 2;
	localparam int flag_v = 1;
	localparam int flag_n = 0;

	// ----------------------------------------------------------
	// Encodings
	// ----------------------------------------------------------
	typedef enum logic [3:0] {
		op_add = 4'h0,
		op_sub = 4'h1,
		op_xor = 4'h2,
		op_and = 4'h3,
		op_sll = 4'h4,  // rt field holds the shift amount
		op_sra = 4'h5,
		op_lw  = 4'h8,
		op_sw  = 4'h9,
		op_lhb = 4'ha,
		op_llb = 4'hb,
		op_b   = 4'hc,  // PC relative
		op_br  = 4'hd,  // Register target
		op_hlt = 4'hf
	} opcode_e;

	typedef enum logic [2:0] {
		cond_ne, cond_eq, cond_gt, cond_lt, cond_ge, cond_le, cond_ovfl, cond_always
	} cond_e;

	typedef enum logic [1:0] {fwd_none, fwd_mem, fwd_wb} fwd_e;

	typedef enum logic [1:0] {arb_idle, arb_req, arb_wait_low} arb_state_e;

	localparam word_t reset_pc   = 16'h0000;  // First fetch
	localparam word_t instr_step = 16'h0002;  // Byte addressed, one word per instr

endpackage
